//--- hw/pool_pkg.sv
package pool_pkg;

  // ************************************************************************
  // widths
  // ************************************************************************

  localparam int LWIDTH = 8;   // sizes and counters
  localparam int DWIDTH = 16;  // pixel width

  typedef logic signed [DWIDTH-1:0] pixel_t;

  // ************************************************************************
  // pooling geometry
  // ************************************************************************

  // largest window edge
  localparam int PSIZE = 3;

  localparam int D_POOLBUF = 18;  // row memory depth = largest feature size

  // strobe pipeline depth when pooling, tied to the max tree depth
  localparam int D_POOL = 3;

endpackage

//--- hw/pool_linebuf_ctrl.sv
`timescale 1ns/1ps

module pool_linebuf_ctrl import pool_pkg::*; #(
  parameter int PSIZE = pool_pkg::PSIZE,
  parameter int D_POOLBUF = pool_pkg::D_POOLBUF,
  localparam int SW = (PSIZE > 1) ? $clog2(PSIZE) : 1,
  localparam int AW = (D_POOLBUF > 1) ? $clog2(D_POOLBUF) : 1
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              buf_req,
  input  logic              in_valid,
  input  logic              in_stop,
  input  logic [LWIDTH-1:0] fea_size_q,
  input  logic [LWIDTH-1:0] pool_size_q,
  output logic              buf_ack,
  output logic              buf_start,
  output logic              buf_valid,
  output logic              buf_stop,
  output logic              buf_we,
  output logic [SW-1:0]     buf_wsel,
  output logic [SW-1:0]     buf_rsel,
  output logic [AW-1:0]     buf_addr
);

  logic              busy;     // inside a pooled frame
  logic [LWIDTH-1:0] col_cnt;
  logic [LWIDTH-1:0] row_cnt;
  logic [SW-1:0]     wsel;     // slot of the current row
  logic              row_end;

  // ************************************************************************
  // position counters and slot rotation
  // ************************************************************************

  assign row_end = (col_cnt == fea_size_q - 1'b1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy    <= 1'b0;
      col_cnt <= '0;
      row_cnt <= '0;
      wsel    <= '0;
    end else if (buf_ack) begin
      busy    <= 1'b1;
      col_cnt <= '0;
      row_cnt <= '0;
      wsel    <= '0;
    end else begin
      if (in_stop)
        busy <= 1'b0;
      if (buf_we) begin
        if (row_end) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
          wsel    <= (wsel == SW'(PSIZE - 1)) ? '0 : wsel + 1'b1;  // oldest slot is reused
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // ************************************************************************
  // buffer strobes
  // ************************************************************************

  assign buf_ack   = buf_req & ~busy;
  assign buf_start = buf_req;
  assign buf_stop  = in_stop & busy;
  assign buf_we    = in_valid & busy;
  assign buf_wsel  = wsel;
  assign buf_rsel  = wsel;  // newest row is the one being written
  assign buf_addr  = col_cnt[AW-1:0];

  // a full window sits behind this pixel (sliding, every position)
  assign buf_valid = buf_we
                  && row_cnt >= pool_size_q - 1'b1
                  && col_cnt >= pool_size_q - 1'b1;

  // no pixel once the last row of the frame is complete
  a_pixel_in_frame: assert property (@(posedge clk) disable iff (!xrst)
    (in_valid && busy) |-> (row_cnt < fea_size_q));

endmodule

//--- hw/pool_linebuf.sv
`timescale 1ns/1ps

module pool_linebuf import pool_pkg::*; #(
  parameter int PSIZE = pool_pkg::PSIZE,
  parameter int D_POOLBUF = pool_pkg::D_POOLBUF,
  localparam int SW = (PSIZE > 1) ? $clog2(PSIZE) : 1,
  localparam int AW = (D_POOLBUF > 1) ? $clog2(D_POOLBUF) : 1
) (
  input  logic          clk,
  input  logic          xrst,
  input  logic          buf_we,
  input  logic [SW-1:0] buf_wsel,
  input  logic [SW-1:0] buf_rsel,
  input  logic [AW-1:0] buf_addr,
  input  pixel_t        in_data,
  output pixel_t        win_data [PSIZE][PSIZE]
);

  pixel_t mem      [PSIZE][D_POOLBUF];  // one slot per buffered row
  pixel_t col_data [PSIZE];             // newest row first

  // ************************************************************************
  // row memories
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (buf_we)
      mem[buf_wsel][buf_addr] <= in_data;
  end

  // older rows come from the slots behind the newest one
  always_comb begin
    int slot;
    slot = 0;
    col_data[0] = in_data;  // current row bypasses the memory
    for (int k = 1; k < PSIZE; k++) begin
      if (int'(buf_rsel) >= k)
        slot = int'(buf_rsel) - k;
      else
        slot = int'(buf_rsel) + PSIZE - k;
      col_data[k] = mem[slot][buf_addr];
    end
  end

  // ************************************************************************
  // window shift register
  // ************************************************************************

  // column 0 holds the newest column, so (0,0) is the newest pixel
  always_ff @(posedge clk) begin
    if (buf_we) begin
      for (int i = 0; i < PSIZE; i++) begin
        win_data[i][0] <= col_data[i];
        for (int j = 1; j < PSIZE; j++)
          win_data[i][j] <= win_data[i][j-1];
      end
    end
  end

  // slot and column stay inside the memories
  a_addr_range: assert property (@(posedge clk) disable iff (!xrst)
    buf_we |-> (int'(buf_wsel) < PSIZE && int'(buf_addr) < D_POOLBUF));

endmodule

//--- hw/pool_max.sv
`timescale 1ns/1ps

module pool_max import pool_pkg::*; #(
  parameter int PSIZE = pool_pkg::PSIZE
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              pool_en,
  input  logic              pool_oe,
  input  logic [LWIDTH-1:0] pool_size_q,
  input  pixel_t            win_data [PSIZE][PSIZE],
  input  pixel_t            in_data,
  output pixel_t            out_data
);

  // most negative pixel so it never wins a comparison
  localparam pixel_t PIX_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

  pixel_t row_max_d [PSIZE];
  pixel_t row_max_q [PSIZE];
  pixel_t win_max;

  // ************************************************************************
  // stage one: row maxima inside the window
  // ************************************************************************

  always_comb begin
    for (int i = 0; i < PSIZE; i++) begin
      if (i >= pool_size_q) begin
        row_max_d[i] = PIX_MIN;  // row outside the window
      end else begin
        row_max_d[i] = win_data[i][0];
        for (int j = 1; j < PSIZE; j++)
          if (j < pool_size_q && win_data[i][j] > row_max_d[i])
            row_max_d[i] = win_data[i][j];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < PSIZE; i++)
      row_max_q[i] <= row_max_d[i];
  end

  // ************************************************************************
  // stage two: maximum over rows, bypass register
  // ************************************************************************

  always_comb begin
    win_max = row_max_q[0];
    for (int i = 1; i < PSIZE; i++)
      if (row_max_q[i] > win_max)
        win_max = row_max_q[i];
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      out_data <= '0;
    else if (!pool_en)
      out_data <= in_data;   // pass-through in one cycle
    else if (pool_oe)
      out_data <= win_max;   // hold until the next window
  end

  // the window behind each emitted maximum was fully written
  for (genvar i = 0; i < PSIZE; i++) begin : g_win_known
    a_win_known: assert property (@(posedge clk) disable iff (!xrst)
      (pool_en && pool_oe) |-> !$isunknown(row_max_q[i]));
  end

endmodule

//--- hw/pool_ctrl.sv
`timescale 1ns/1ps

module pool_ctrl import pool_pkg::*; (
  input  logic              clk,
  input  logic              xrst,
  input  logic              pool_en,
  input  logic              in_start,
  input  logic              in_valid,
  input  logic              in_stop,
  input  logic [LWIDTH-1:0] fea_size,
  input  logic [LWIDTH-1:0] pool_size,
  input  logic              buf_ack,
  input  logic              buf_start,
  input  logic              buf_valid,
  input  logic              buf_stop,
  output logic              buf_req,
  output logic [LWIDTH-1:0] fea_size_q,
  output logic [LWIDTH-1:0] pool_size_q,
  output logic              pool_oe,
  output logic              out_start,
  output logic              out_valid,
  output logic              out_stop
);

  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } state_t;

  state_t            state;
  logic [LWIDTH-1:0] pool_x;   // sliding window index within a row
  logic [LWIDTH-1:0] exec_x;   // column phase inside the pool window
  logic [LWIDTH-1:0] exec_y;   // row phase inside the pool window
  logic              row_last;
  logic              win_hit;

  logic [D_POOL-1:0] stg_start;
  logic [D_POOL-1:0] stg_valid;
  logic [D_POOL-1:0] stg_stop;

  // ************************************************************************
  // frame FSM and size latch
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT:   if (in_start) state <= S_ACTIVE;
        S_ACTIVE: if (out_stop) state <= S_WAIT;
        default:  state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fea_size_q  <= '0;
      pool_size_q <= '0;
    end else if (state == S_WAIT && in_start) begin
      fea_size_q  <= fea_size;
      pool_size_q <= pool_size;
    end
  end

  assign buf_req = in_start & pool_en;

  // ************************************************************************
  // window phase
  // ************************************************************************

  assign row_last = (pool_x == fea_size_q - pool_size_q);  // last window of the row

  always_ff @(posedge clk) begin
    if (!xrst || buf_ack) begin
      pool_x <= '0;
      exec_x <= '0;
      exec_y <= '0;
    end else if (buf_valid) begin
      if (row_last) begin
        pool_x <= '0;
        exec_x <= '0;
        exec_y <= (exec_y == pool_size_q - 1'b1) ? '0 : exec_y + 1'b1;
      end else begin
        pool_x <= pool_x + 1'b1;
        exec_x <= (exec_x == pool_size_q - 1'b1) ? '0 : exec_x + 1'b1;
      end
    end
  end

  // only non-overlapping windows are emitted
  assign win_hit = buf_valid && exec_x == '0 && exec_y == '0;

  // ************************************************************************
  // strobe pipeline
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      stg_start <= '0;
      stg_valid <= '0;
      stg_stop  <= '0;
    end else begin
      if (pool_en) begin
        stg_start[0] <= buf_start;
        stg_valid[0] <= win_hit;
        stg_stop[0]  <= buf_stop;
      end else begin
        stg_start[0] <= in_start;  // bypass, raw strobes
        stg_valid[0] <= in_valid;
        stg_stop[0]  <= in_stop;
      end
      for (int i = 1; i < D_POOL; i++) begin
        stg_start[i] <= stg_start[i-1];
        stg_valid[i] <= stg_valid[i-1];
        stg_stop[i]  <= stg_stop[i-1];
      end
    end
  end

  assign out_start = pool_en ? stg_start[D_POOL-1] : stg_start[0];
  assign out_valid = pool_en ? stg_valid[D_POOL-1] : stg_valid[0];
  assign out_stop  = pool_en ? stg_stop[D_POOL-1]  : stg_stop[0];

  assign pool_oe = stg_valid[D_POOL-2];  // loads the last max stage

  // a new frame only after the previous one has left the stage
  a_start_idle: assert property (@(posedge clk) disable iff (!xrst)
    in_start |-> (state == S_WAIT));

endmodule

//--- hw/pool_top.sv
`timescale 1ns/1ps

module pool_top import pool_pkg::*; #(
  parameter int PSIZE = pool_pkg::PSIZE,
  parameter int D_POOLBUF = pool_pkg::D_POOLBUF,
  localparam int SW = (PSIZE > 1) ? $clog2(PSIZE) : 1,
  localparam int AW = (D_POOLBUF > 1) ? $clog2(D_POOLBUF) : 1
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              pool_en,
  input  logic              in_start,
  input  logic              in_valid,
  input  logic              in_stop,
  input  logic [LWIDTH-1:0] fea_size,
  input  logic [LWIDTH-1:0] pool_size,
  input  pixel_t            in_data,
  output logic              out_start,
  output logic              out_valid,
  output logic              out_stop,
  output pixel_t            out_data
);

  // control to line buffer control
  logic              buf_req;
  logic              buf_ack;
  logic              buf_start;
  logic              buf_valid;
  logic              buf_stop;
  logic [LWIDTH-1:0] fea_size_q;
  logic [LWIDTH-1:0] pool_size_q;

  // line buffer control to memories
  logic              buf_we;
  logic [SW-1:0]     buf_wsel;
  logic [SW-1:0]     buf_rsel;
  logic [AW-1:0]     buf_addr;

  pixel_t            win_data [PSIZE][PSIZE];
  logic              pool_oe;

  // ************************************************************************
  // control path
  // ************************************************************************

  pool_ctrl ctrl_inst (
    .clk, .xrst, .pool_en, .in_start, .in_valid, .in_stop,
    .fea_size, .pool_size,
    .buf_ack, .buf_start, .buf_valid, .buf_stop, .buf_req,
    .fea_size_q, .pool_size_q,
    .pool_oe, .out_start, .out_valid, .out_stop
  );

  pool_linebuf_ctrl #(.PSIZE(PSIZE), .D_POOLBUF(D_POOLBUF)) linebuf_ctrl_inst (
    .clk, .xrst, .buf_req, .in_valid, .in_stop,
    .fea_size_q, .pool_size_q,
    .buf_ack, .buf_start, .buf_valid, .buf_stop,
    .buf_we, .buf_wsel, .buf_rsel, .buf_addr
  );

  // ************************************************************************
  // data path
  // ************************************************************************

  pool_linebuf #(.PSIZE(PSIZE), .D_POOLBUF(D_POOLBUF)) linebuf_inst (
    .clk, .xrst, .buf_we, .buf_wsel, .buf_rsel, .buf_addr,
    .in_data, .win_data
  );

  pool_max #(.PSIZE(PSIZE)) max_inst (
    .clk, .xrst, .pool_en, .pool_oe, .pool_size_q,
    .win_data, .in_data, .out_data
  );

endmodule

//--- tb/tb_pool_top.sv
`timescale 1ns/1ps

module tb_pool_top import pool_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 4;
  localparam int LAT_POOL   = 3;  // window register plus two max stages
  localparam int LAT_BYPASS = 1;
  localparam int N_FRAMES   = 9;

  logic              clk;
  logic              xrst;
  logic              pool_en;
  logic              in_start;
  logic              in_valid;
  logic              in_stop;
  logic [LWIDTH-1:0] fea_size;
  logic [LWIDTH-1:0] pool_size;
  pixel_t            in_data;
  logic              out_start;
  logic              out_valid;
  logic              out_stop;
  pixel_t            out_data;

  // mode, feature size and window size of each frame
  int frame_en  [N_FRAMES] = '{0, 1, 1, 1, 1, 0, 1, 1, 0};
  int frame_fea [N_FRAMES] = '{6, 8, 9, 4, 6, 5, 18, 12, 4};
  int frame_psz [N_FRAMES] = '{2, 2, 3, 1, 3, 1, 2, 3, 1};

  int          cyc;          // posedges seen so far
  int          cycle_limit;
  logic [31:0] rng;

  // expected outputs, each with its due cycle
  int     start_due [$];
  int     stop_due  [$];
  int     valid_due [$];
  pixel_t valid_val [$];

  pixel_t frame_pix [D_POOLBUF][D_POOLBUF];  // pixels of the current frame

  pool_top #(.PSIZE(PSIZE), .D_POOLBUF(D_POOLBUF)) pool_top_inst (
    .clk, .xrst, .pool_en, .in_start, .in_valid, .in_stop,
    .fea_size, .pool_size, .in_data,
    .out_start, .out_valid, .out_stop, .out_data
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // **************************************************************************
  // helpers
  // **************************************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // max over the psz x psz block ending at (r, c)
  function automatic pixel_t block_max(input int r, input int c, input int psz);
    pixel_t m;
    m = frame_pix[r][c];
    for (int i = r - psz + 1; i <= r; i++)
      for (int j = c - psz + 1; j <= c; j++)
        if (frame_pix[i][j] > m)
          m = frame_pix[i][j];
    return m;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_strobe(input logic actual, input logic expected, input string what);
    if (actual !== expected)
      abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b",
                          $time, what, actual, expected));
  endtask

  task automatic check_data(input pixel_t actual, input pixel_t expected, input string what);
    if (actual !== expected)
      abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d",
                          $time, what, actual, expected));
  endtask

  task automatic drive_cycle(input logic start, input logic valid, input logic stop,
                             input pixel_t data);
    @(negedge clk);
    in_start = start;
    in_valid = valid;
    in_stop  = stop;
    in_data  = data;
  endtask

  // **************************************************************************
  // cycle count, timeout and output monitor
  // **************************************************************************

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit)
      abort_run("timeout: outputs missing");
  end

  // outputs only change on posedge, so the falling edge sees them settled
  always @(negedge clk) begin : out_monitor
    logic due;
    if (xrst) begin
      due = (start_due.size() != 0 && start_due[0] == cyc);
      check_strobe(out_start, due, "out_start");
      if (due)
        void'(start_due.pop_front());
      due = (stop_due.size() != 0 && stop_due[0] == cyc);
      check_strobe(out_stop, due, "out_stop");
      if (due)
        void'(stop_due.pop_front());
      due = (valid_due.size() != 0 && valid_due[0] == cyc);
      check_strobe(out_valid, due, "out_valid");
      if (due) begin
        check_data(out_data, valid_val[0], "out_data");
        void'(valid_due.pop_front());
        void'(valid_val.pop_front());
      end
    end
  end

  // **************************************************************************
  // one frame with random pixels and gaps
  // **************************************************************************

  task automatic run_frame(input logic en, input int fea, input int psz);
    int     lat;
    int     gap;
    pixel_t px;
    lat = en ? LAT_POOL : LAT_BYPASS;
    @(negedge clk);
    pool_en   = en;  // sizes settle one cycle before start
    fea_size  = LWIDTH'(fea);
    pool_size = LWIDTH'(psz);
    drive_cycle(1'b1, 1'b0, 1'b0, '0);
    start_due.push_back(cyc + lat);
    for (int r = 0; r < fea; r++) begin
      for (int c = 0; c < fea; c++) begin
        rng = xorshift32(rng);
        gap = int'(rng % 3);
        repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, '0);
        rng = xorshift32(rng);
        px  = pixel_t'(rng[DWIDTH-1:0]);
        drive_cycle(1'b0, 1'b1, 1'b0, px);
        frame_pix[r][c] = px;
        if (!en) begin
          valid_due.push_back(cyc + lat);
          valid_val.push_back(px);
        end else if ((r + 1) % psz == 0 && (c + 1) % psz == 0) begin
          valid_due.push_back(cyc + lat);  // block completes here
          valid_val.push_back(block_max(r, c, psz));
        end
      end
    end
    rng = xorshift32(rng);
    gap = int'(rng % 3);
    repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, '0);
    drive_cycle(1'b0, 1'b0, 1'b1, '0);
    stop_due.push_back(cyc + lat);
    drive_cycle(1'b0, 1'b0, 1'b0, '0);
    // wait for out_stop, then let the FSM fall back to wait
    while (start_due.size() != 0 || valid_due.size() != 0 || stop_due.size() != 0)
      @(posedge clk);
    repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, '0);
  endtask

  // **************************************************************************
  // main sequence
  // **************************************************************************

  initial begin
    clk       = 1'b0;
    xrst      = 1'b0;
    pool_en   = 1'b0;
    in_start  = 1'b0;
    in_valid  = 1'b0;
    in_stop   = 1'b0;
    fea_size  = '0;
    pool_size = '0;
    in_data   = '0;
    cyc       = 0;
    rng       = 32'h23c0;

    // up to 3 cycles per pixel, plus setup and drain per frame
    cycle_limit = RST_CYCLES;
    for (int f = 0; f < N_FRAMES; f++)
      cycle_limit += frame_fea[f] * frame_fea[f] * 3 + 50;

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;

    repeat (5) drive_cycle(1'b0, 1'b0, 1'b0, '0);  // quiet outputs before any frame

    for (int f = 0; f < N_FRAMES; f++)
      run_frame(frame_en[f] != 0, frame_fea[f], frame_psz[f]);

    $display("No errors");
    $finish;
  end

endmodule

//--- vlog.f
hw/pool_pkg.sv
hw/pool_linebuf_ctrl.sv
hw/pool_linebuf.sv
hw/pool_max.sv
hw/pool_ctrl.sv
hw/pool_top.sv
tb/tb_pool_top.sv

//--- Bender.yml
package:
  name: pool

sources:
  - hw/pool_pkg.sv
  - hw/pool_linebuf_ctrl.sv
  - hw/pool_linebuf.sv
  - hw/pool_max.sv
  - hw/pool_ctrl.sv
  - hw/pool_top.sv
  - target: test
    files:
      - tb/tb_pool_top.sv
